// File: build.f
+incdir+hw
hw/spi_flash_pkg.sv
hw/flash_req_arbiter.sv
hw/spi_read_master.sv
hw/serial_flash_device.sv
hw/spi_flash_top.sv
verif/tb_spi_flash.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator and run the flash subsystem testbench.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_spi_flash -o tb_sim

# The simulator exits non-zero on a fatal error; the log decides the result.
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
exit 1

// File: verif/tb_spi_flash.sv
`timescale 1ns/100ps
`include "spi_flash_consts.svh"

module tb_spi_flash import spi_flash_pkg::*; ();

  localparam int TIMEOUT = 2000;
  localparam flash_addr_t ADDR_A = 24'h000100;

  logic        sck;
  logic        reset;
  logic        req0_valid;
  logic        req0_ready;
  flash_req_t  req0;
  logic        req1_valid;
  logic        req1_ready;
  flash_req_t  req1;
  logic        rsp0_valid;
  logic        rsp0_ready;
  logic        rsp1_valid;
  logic        rsp1_ready;
  flash_rsp_t  rsp;

  // Expected flash contents, one entry per byte.
  logic [7:0]  ref_mem [`FLASH_BYTES];
  logic [31:0] rng_state;
  logic        last_grant;

  spi_flash_top u_dut (
    .sck        (sck),
    .reset      (reset),
    .req0_valid (req0_valid),
    .req0_ready (req0_ready),
    .req0       (req0),
    .req1_valid (req1_valid),
    .req1_ready (req1_ready),
    .req1       (req1),
    .rsp0_valid (rsp0_valid),
    .rsp0_ready (rsp0_ready),
    .rsp1_valid (rsp1_valid),
    .rsp1_ready (rsp1_ready),
    .rsp        (rsp)
  );

  initial begin
    sck = 1'b0;
    forever #5 sck = ~sck;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_word(input string name, input flash_word_t got, input flash_word_t exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_port(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic expect_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic flash_req_t make_req(input flash_cmd_t cmd, input flash_addr_t addr,
                                          input flash_word_t wdata);
    flash_req_t r;
    r.cmd   = cmd;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  // Byte k of a word sits at address plus k, wrapping around the array.
  function automatic flash_word_t ref_read(input flash_addr_t addr);
    flash_word_t w;
    for (int k = 0; k < 4; k++) begin
      w[8*k +: 8] = ref_mem[(int'(addr) + k) % `FLASH_BYTES];
    end
    return w;
  endfunction

  // NOR program only clears bits.
  task automatic ref_program(input flash_addr_t addr, input flash_word_t w);
    int idx;
    for (int k = 0; k < 4; k++) begin
      idx = (int'(addr) + k) % `FLASH_BYTES;
      ref_mem[idx] = ref_mem[idx] & w[8*k +: 8];
    end
  endtask

  task automatic wait_accept(input logic port);
    int   n;
    logic acc;
    n = 0;
    acc = 1'b0;
    while (!acc) begin
      @(negedge sck);
      acc = port ? req1_ready : req0_ready;
      n++;
      if (!acc && n > TIMEOUT) begin
        fail_now($sformatf("Request on port %0d was not accepted in time.", port));
      end
    end
    @(posedge sck);
    if (port) begin
      req1_valid <= 1'b0;
    end else begin
      req0_valid <= 1'b0;
    end
    last_grant = port;
  endtask

  task automatic send_req(input logic port, input flash_req_t r);
    @(posedge sck);
    if (port) begin
      req1_valid <= 1'b1;
      req1       <= r;
    end else begin
      req0_valid <= 1'b1;
      req0       <= r;
    end
    wait_accept(port);
  endtask

  task automatic wait_rsp(output logic port, output flash_word_t data);
    int n;
    n = 0;
    while (!((rsp0_valid && rsp0_ready) || (rsp1_valid && rsp1_ready))) begin
      @(negedge sck);
      n++;
      if (n > TIMEOUT) begin
        fail_now("No response arrived in time.");
      end
    end
    if (rsp0_valid && rsp1_valid) begin
      fail_now("Both ports got a response in the same cycle.");
    end
    port = rsp1_valid;
    data = rsp.rdata;
    @(posedge sck);
  endtask

  // One full request and response, checked against the reference array.
  task automatic do_op(input logic port, input flash_cmd_t cmd, input flash_addr_t addr,
                       input flash_word_t wdata, output flash_word_t data);
    flash_word_t exp;
    logic        got_port;
    exp = (cmd == `CMD_READ) ? ref_read(addr) : wdata;
    send_req(port, make_req(cmd, addr, wdata));
    wait_rsp(got_port, data);
    check_port("responding port", got_port, port);
    check_word("rsp.rdata", data, exp);
    if (cmd == `CMD_PROGRAM) begin
      ref_program(addr, wdata);
    end
  endtask

  task automatic after_reset();
    flash_word_t data;
    repeat (3) begin
      @(negedge sck);
      expect_flag("req0_ready", req0_ready, 1'b0);
      expect_flag("req1_ready", req1_ready, 1'b0);
      expect_flag("rsp0_valid", rsp0_valid, 1'b0);
      expect_flag("rsp1_valid", rsp1_valid, 1'b0);
    end
    rng_state = xorshift(rng_state);
    do_op(1'b0, `CMD_READ, rng_state[23:0], '0, data);
    check_word("erased word", data, 32'hffff_ffff);
  endtask

  task automatic program_readback();
    flash_word_t data;
    do_op(1'b0, `CMD_PROGRAM, ADDR_A, 32'ha5c3_1e69, data);
    do_op(1'b1, `CMD_READ, ADDR_A, '0, data);
    check_word("readback", data, 32'ha5c3_1e69);
    // One byte up, the erased byte after the word moves into the top.
    do_op(1'b1, `CMD_READ, ADDR_A + 24'd1, '0, data);
    check_word("offset readback", data, 32'hffa5_c31e);
  endtask

  task automatic program_twice();
    flash_word_t data;
    do_op(1'b1, `CMD_PROGRAM, ADDR_A, 32'h0f0f_f0f0, data);
    do_op(1'b0, `CMD_READ, ADDR_A, '0, data);
    check_word("second program", data, 32'h0503_1060);
  endtask

  task automatic contend(input flash_addr_t addr0, input flash_addr_t addr1);
    flash_word_t exp0;
    flash_word_t exp1;
    logic        first;
    logic        acc0;
    logic        acc1;
    logic        port;
    int          grants;
    int          rsps;
    int          n;
    exp0   = ref_read(addr0);
    exp1   = ref_read(addr1);
    // Priority sits with the port that was not granted last.
    first  = ~last_grant;
    grants = 0;
    rsps   = 0;
    n      = 0;
    @(posedge sck);
    req0_valid <= 1'b1;
    req0       <= make_req(`CMD_READ, addr0, '0);
    req1_valid <= 1'b1;
    req1       <= make_req(`CMD_READ, addr1, '0);
    while (rsps < 2) begin
      @(negedge sck);
      n++;
      if (n > 2 * TIMEOUT) begin
        fail_now("Contending requests did not both complete in time.");
      end
      acc0 = req0_ready;
      acc1 = req1_ready;
      if (acc0 || acc1) begin
        check_port("granted port", acc1, (grants == 0) ? first : ~first);
        last_grant = acc1;
        grants++;
      end
      if (rsp0_valid || rsp1_valid) begin
        if (rsp0_valid && rsp1_valid) begin
          fail_now("Both ports got a response in the same cycle.");
        end
        port = rsp1_valid;
        check_port("responding port", port, (rsps == 0) ? first : ~first);
        check_word("rsp.rdata", rsp.rdata, port ? exp1 : exp0);
        rsps++;
      end
      @(posedge sck);
      if (acc0) begin
        req0_valid <= 1'b0;
      end
      if (acc1) begin
        req1_valid <= 1'b0;
      end
    end
  endtask

  task automatic backpressure();
    flash_word_t exp0;
    flash_word_t held;
    flash_word_t data;
    logic        port;
    int          n;
    exp0 = ref_read(ADDR_A);
    @(posedge sck);
    rsp0_ready <= 1'b0;
    send_req(1'b0, make_req(`CMD_READ, ADDR_A, '0));
    @(posedge sck);
    req1_valid <= 1'b1;
    req1       <= make_req(`CMD_PROGRAM, 24'h000200, 32'h1234_5678);
    n = 0;
    while (!rsp0_valid) begin
      @(negedge sck);
      expect_flag("req1_ready", req1_ready, 1'b0);
      n++;
      if (n > TIMEOUT) begin
        fail_now("Port 0 response did not arrive in time.");
      end
    end
    held = rsp.rdata;
    check_word("rsp.rdata", held, exp0);
    repeat (20) begin
      @(negedge sck);
      expect_flag("rsp0_valid", rsp0_valid, 1'b1);
      expect_flag("rsp1_valid", rsp1_valid, 1'b0);
      expect_flag("req1_ready", req1_ready, 1'b0);
      check_word("held rsp.rdata", rsp.rdata, held);
    end
    @(posedge sck);
    rsp0_ready <= 1'b1;
    @(negedge sck);
    expect_flag("req1_ready", req1_ready, 1'b0);
    wait_accept(1'b1);
    wait_rsp(port, data);
    check_port("responding port", port, 1'b1);
    check_word("rsp.rdata", data, 32'h1234_5678);
    ref_program(24'h000200, 32'h1234_5678);
  endtask

  task automatic random_ops();
    logic [31:0] r;
    flash_addr_t addr;
    flash_word_t data;
    for (int i = 0; i < 30; i++) begin
      rng_state = xorshift(rng_state);
      r = rng_state;
      // Keep to the top of the array so that some words wrap to address 0.
      addr = {r[23:10], 5'b11111, r[4:0]};
      rng_state = xorshift(rng_state);
      do_op(r[31], r[30] ? `CMD_PROGRAM : `CMD_READ, addr, rng_state, data);
    end
  endtask

  initial begin
    reset      = 1'b1;
    req0_valid = 1'b0;
    req0       = '0;
    req1_valid = 1'b0;
    req1       = '0;
    rsp0_ready = 1'b1;
    rsp1_ready = 1'b1;
    rng_state  = 32'd26461;
    last_grant = 1'b1;
    for (int i = 0; i < `FLASH_BYTES; i++) begin
      ref_mem[i] = 8'hff;
    end
    repeat (5) @(posedge sck);
    reset <= 1'b0;
    after_reset();
    program_readback();
    program_twice();
    contend(ADDR_A, 24'h000300);
    contend(24'h000300, ADDR_A);
    backpressure();
    random_ops();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: hw/spi_flash_top.sv
`timescale 1ns/100ps

module spi_flash_top import spi_flash_pkg::*; (
  input  logic       sck,
  input  logic       reset,
  input  logic       req0_valid,
  output logic       req0_ready,
  input  flash_req_t req0,
  input  logic       req1_valid,
  output logic       req1_ready,
  input  flash_req_t req1,
  output logic       rsp0_valid,
  input  logic       rsp0_ready,
  output logic       rsp1_valid,
  input  logic       rsp1_ready,
  output flash_rsp_t rsp
);

  logic       m_req_valid;
  logic       m_req_ready;
  flash_req_t m_req;
  logic       m_rsp_valid;
  logic       m_rsp_ready;
  flash_rsp_t m_rsp;
  spi_bus_t   bus;
  logic       miso;

  flash_req_arbiter u_arb (
    .sck         (sck),
    .reset       (reset),
    .req0_valid  (req0_valid),
    .req0_ready  (req0_ready),
    .req0        (req0),
    .req1_valid  (req1_valid),
    .req1_ready  (req1_ready),
    .req1        (req1),
    .rsp0_valid  (rsp0_valid),
    .rsp0_ready  (rsp0_ready),
    .rsp1_valid  (rsp1_valid),
    .rsp1_ready  (rsp1_ready),
    .rsp         (rsp),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req       (m_req),
    .m_rsp_valid (m_rsp_valid),
    .m_rsp_ready (m_rsp_ready),
    .m_rsp       (m_rsp)
  );

  spi_read_master u_master (
    .sck       (sck),
    .reset     (reset),
    .req_valid (m_req_valid),
    .req_ready (m_req_ready),
    .req       (m_req),
    .rsp_valid (m_rsp_valid),
    .rsp_ready (m_rsp_ready),
    .rsp       (m_rsp),
    .bus       (bus),
    .miso      (miso)
  );

  serial_flash_device u_dev (
    .bus  (bus),
    .miso (miso)
  );

endmodule

// File: hw/serial_flash_device.sv
`timescale 1ns/100ps
`include "spi_flash_consts.svh"

module serial_flash_device import spi_flash_pkg::*; (
  input  spi_bus_t bus,
  output logic     miso
);

  typedef enum logic [1:0] {
    d_cmd,
    d_addr,
    d_data
  } dev_state_t;

  logic                 spi_clk;
  logic                 cs_n;
  logic                 mosi;
  dev_state_t           state;
  logic [5:0]           bit_cnt;
  flash_cmd_t           cmd;
  flash_addr_t          addr;
  flash_addr_t          full_addr;
  logic [7:0]           wr_byte;
  logic [7:0]           wr_data;
  logic [`FLASH_AW-1:0] rd_base;
  logic [`FLASH_AW-1:0] wr_ptr;
  logic                 byte_done;
  flash_word_t          out_sr;
  logic                 miso_q;
  logic [7:0]           mem [`FLASH_BYTES];

  assign spi_clk = bus.spi_clk;
  assign cs_n    = bus.cs_n;
  assign mosi    = bus.mosi;

  // Address including the bit arriving on this edge.
  assign full_addr = {addr[22:0], mosi};
  assign rd_base   = full_addr[`FLASH_AW-1:0];

  // Byte k of the data phase lands at base plus k.
  assign wr_ptr    = addr[`FLASH_AW-1:0] + `FLASH_AW'(bit_cnt[4:3]);
  assign wr_data   = {wr_byte[6:0], mosi};
  assign byte_done = (state == d_data) && (cmd == `CMD_PROGRAM) && (bit_cnt[2:0] == 3'd7);

  // Erased array.
  initial begin
    for (int i = 0; i < `FLASH_BYTES; i++) begin
      mem[i] = 8'hff;
    end
  end

  always_ff @(posedge spi_clk or posedge cs_n) begin
    if (cs_n) begin
      state   <= d_cmd;
      bit_cnt <= '0;
      cmd     <= '0;
      addr    <= '0;
    end else begin
      bit_cnt <= bit_cnt + 6'd1;
      case (state)
        d_cmd: begin
          cmd <= {cmd[6:0], mosi};
          if (bit_cnt == 6'd7) begin
            state <= d_addr;
          end
        end
        d_addr: begin
          addr <= full_addr;
          if (bit_cnt == 6'd31) begin
            state <= d_data;
          end
        end
        default: state <= d_data;
      endcase
    end
  end

  // Read word is fetched on the last address bit, byte 0 in the top bits.
  always_ff @(posedge spi_clk) begin
    if (state == d_data) begin
      wr_byte <= wr_data;
    end
    if (state == d_addr && bit_cnt == 6'd31) begin
      out_sr <= {mem[rd_base], mem[rd_base + `FLASH_AW'(1)],
                 mem[rd_base + `FLASH_AW'(2)], mem[rd_base + `FLASH_AW'(3)]};
    end else if (state == d_data) begin
      out_sr <= {out_sr[30:0], 1'b1};
    end
  end

  // NOR program can only clear bits.
  always @(posedge spi_clk) begin
    if (byte_done) begin
      mem[wr_ptr] <= mem[wr_ptr] & wr_data;
    end
  end

  // miso moves on the falling edge.
  always_ff @(negedge spi_clk or posedge cs_n) begin
    if (cs_n) begin
      miso_q <= 1'b1;
    end else begin
      miso_q <= (state == d_data) ? out_sr[31] : 1'b1;
    end
  end

  assign miso = cs_n ? 1'b1 : miso_q;

  a_cmd_known: assert property (@(posedge spi_clk) disable iff (cs_n)
    (state == d_addr) |-> (cmd == `CMD_READ || cmd == `CMD_PROGRAM))
    else $error("Unsupported flash command %02xh.", cmd);

endmodule

// File: hw/spi_read_master.sv
`timescale 1ns/100ps
`include "spi_flash_consts.svh"

module spi_read_master import spi_flash_pkg::*; (
  input  logic       sck,
  input  logic       reset,
  input  logic       req_valid,
  output logic       req_ready,
  input  flash_req_t req,
  output logic       rsp_valid,
  input  logic       rsp_ready,
  output flash_rsp_t rsp,
  output spi_bus_t   bus,
  input  logic       miso
);

  localparam int PHASE_W = $clog2(2 * `SPI_HALF);
  localparam logic [PHASE_W-1:0] PH_RISE = PHASE_W'(`SPI_HALF - 1);
  localparam logic [PHASE_W-1:0] PH_FALL = PHASE_W'(2 * `SPI_HALF - 1);

  typedef enum logic [2:0] {
    s_idle,
    s_setup,
    s_shift,
    s_hold,
    s_respond
  } mst_state_t;

  mst_state_t         state;
  logic [PHASE_W-1:0] phase;
  logic [5:0]         bit_cnt;
  logic [63:0]        sr;
  flash_word_t        rx;
  logic               is_read;
  logic               rise;
  logic               fall;
  logic               last_bit;

  // Byte 0 travels first on the wire.
  function automatic flash_word_t byte_swap(input flash_word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  assign rise     = (state == s_shift) && (phase == PH_RISE);
  assign fall     = (state == s_shift) && (phase == PH_FALL);
  assign last_bit = (bit_cnt == 6'd63);

  assign req_ready = (state == s_idle);
  assign rsp_valid = (state == s_respond);

  always_ff @(posedge sck or posedge reset) begin
    if (reset) begin
      state   <= s_idle;
      phase   <= '0;
      bit_cnt <= '0;
      bus     <= '{spi_clk: 1'b0, cs_n: 1'b1, mosi: 1'b0};
    end else begin
      case (state)
        s_idle: begin
          // First command bit is on mosi before the first rising edge.
          if (req_valid) begin
            state    <= s_setup;
            bus.cs_n <= 1'b0;
            bus.mosi <= req.cmd[7];
          end
        end
        s_setup: begin
          state   <= s_shift;
          phase   <= '0;
          bit_cnt <= '0;
        end
        s_shift: begin
          phase <= fall ? '0 : phase + 1'b1;
          if (rise) begin
            bus.spi_clk <= 1'b1;
          end
          if (fall) begin
            bus.spi_clk <= 1'b0;
            bus.mosi    <= sr[62];
            if (last_bit) begin
              state <= s_hold;
            end else begin
              bit_cnt <= bit_cnt + 6'd1;
            end
          end
        end
        s_hold: begin
          state    <= s_respond;
          bus.cs_n <= 1'b1;
        end
        s_respond: begin
          if (rsp_ready) begin
            state <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // Shift register, receive register and response word.
  always_ff @(posedge sck) begin
    if (state == s_idle && req_valid) begin
      sr        <= {req.cmd, req.addr, byte_swap(req.wdata)};
      is_read   <= (req.cmd == `CMD_READ);
      rsp.rdata <= req.wdata;
    end
    // miso is sampled together with the rising serial clock
    if (rise) begin
      rx <= {rx[30:0], miso};
    end
    if (fall) begin
      sr <= {sr[62:0], 1'b0};
    end
    // Last 32 bits received are the read word, byte 0 first.
    if (state == s_hold && is_read) begin
      rsp.rdata <= byte_swap(rx);
    end
  end

  a_idle_deselect: assert property (@(posedge sck) disable iff (reset)
    (state == s_idle) |-> bus.cs_n)
    else $error("Chip select active while the master is idle.");

endmodule

// File: hw/flash_req_arbiter.sv
`timescale 1ns/100ps
`include "spi_flash_consts.svh"

module flash_req_arbiter import spi_flash_pkg::*; (
  input  logic       sck,
  input  logic       reset,
  input  logic       req0_valid,
  output logic       req0_ready,
  input  flash_req_t req0,
  input  logic       req1_valid,
  output logic       req1_ready,
  input  flash_req_t req1,
  output logic       rsp0_valid,
  input  logic       rsp0_ready,
  output logic       rsp1_valid,
  input  logic       rsp1_ready,
  output flash_rsp_t rsp,
  output logic       m_req_valid,
  input  logic       m_req_ready,
  output flash_req_t m_req,
  input  logic       m_rsp_valid,
  output logic       m_rsp_ready,
  input  flash_rsp_t m_rsp
);

  typedef enum logic {
    a_idle,
    a_busy
  } arb_state_t;

  arb_state_t state;
  logic       rr_ptr;
  logic       owner;
  logic       any_req;
  logic       sel;
  logic       grant;

  // With both ports asking, the pointer decides; otherwise take whoever asks.
  assign any_req = req0_valid | req1_valid;
  assign sel     = (req0_valid && req1_valid) ? rr_ptr : req1_valid;

  assign m_req_valid = (state == a_idle) && any_req;
  assign m_req       = sel ? req1 : req0;
  assign grant       = m_req_valid && m_req_ready;
  assign req0_ready  = grant && !sel;
  assign req1_ready  = grant && sel;

  // Response goes back to the owner only.
  assign rsp0_valid  = (state == a_busy) && !owner && m_rsp_valid;
  assign rsp1_valid  = (state == a_busy) && owner && m_rsp_valid;
  assign m_rsp_ready = (state == a_busy) && (owner ? rsp1_ready : rsp0_ready);
  assign rsp         = m_rsp;

  always_ff @(posedge sck or posedge reset) begin
    if (reset) begin
      state  <= a_idle;
      rr_ptr <= 1'b0;
      owner  <= 1'b0;
    end else begin
      case (state)
        a_idle: begin
          if (grant) begin
            owner  <= sel;
            rr_ptr <= ~sel;
            state  <= a_busy;
          end
        end
        a_busy: begin
          if (m_rsp_valid && m_rsp_ready) begin
            state <= a_idle;
          end
        end
        default: state <= a_idle;
      endcase
    end
  end

  // A response from the master always belongs to a granted port.
  a_rsp_owned: assert property (@(posedge sck) disable iff (reset)
    (state == a_idle) |-> !m_rsp_valid)
    else $error("Master response with no owning port.");

endmodule

// File: hw/spi_flash_pkg.sv
package spi_flash_pkg;

  // Flash command byte.
  typedef logic [7:0] flash_cmd_t;

  // Byte address as sent on the wire.
  typedef logic [23:0] flash_addr_t;

  // Data word, byte 0 in bits 7:0.
  typedef logic [31:0] flash_word_t;

  typedef struct packed {
    flash_cmd_t  cmd;
    flash_addr_t addr;
    flash_word_t wdata;
  } flash_req_t;

  // For a program this returns the word that was written.
  typedef struct packed {
    flash_word_t rdata;
  } flash_rsp_t;

  // Serial bus from master to device.
  typedef struct packed {
    logic spi_clk;
    logic cs_n;
    logic mosi;
  } spi_bus_t;

endpackage

// File: hw/spi_flash_consts.svh
`ifndef SPI_FLASH_CONSTS_SVH
`define SPI_FLASH_CONSTS_SVH

// Flash command codes understood by the device model.
`define CMD_READ 8'h03
`define CMD_PROGRAM 8'h02

// Size of the byte array in the device model.
`define FLASH_BYTES 1024

// Address bits actually decoded, log2 of the array size.
// Higher address bits are ignored, so addresses wrap.
`define FLASH_AW 10

// System clock cycles per serial clock phase.
// One serial bit takes twice this many cycles.
`define SPI_HALF 2

`endif
